//--- rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int unsigned INST_W = 32;
    localparam int unsigned OPCODE_W = 7;

    // Field positions inside the instruction word
    localparam int unsigned RD_LSB = 7;
    localparam int unsigned FUNCT3_LSB = 12;
    localparam int unsigned RS1_LSB = 15;
    localparam int unsigned RS2_LSB = 20;
    localparam int unsigned FUNCT7_LSB = 25;

    typedef enum logic [OPCODE_W-1:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3_e;

    // Selects SUB and SRA/SRAI
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    // ADDI x0, x0, 0
    localparam logic [INST_W-1:0] INST_NOP = {12'b0, 5'b0, 3'b000, 5'b0, OP_IMM};

endpackage

`default_nettype wire

//--- rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    localparam int unsigned XLEN = 32;
    localparam int unsigned REG_AW = 5;
    localparam int unsigned PC_W = 32;

    localparam logic [PC_W-1:0] RESET_PC = '0;
    localparam logic [PC_W-1:0] PC_STEP = 32'd4;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        // LUI result is the immediate itself
        ALU_PASS_B
    } alu_op_e;

endpackage

`default_nettype wire

//--- rv_fetch.sv
`default_nettype none

module rv_fetch (
    input  logic                         clk_wfi,
    input  logic                         rstn_sync,
    input  logic                         imem_busy_i,
    output logic                         imem_en_o,
    output logic [rv_core_pkg::PC_W-1:0] imem_addr_o,
    output logic                         fetch_valid_o,
    output logic [rv_core_pkg::PC_W-1:0] fetch_pc_o
);

    logic accept;

    assign accept = imem_en_o && !imem_busy_i;

    // imem_addr_o is the PC and only moves on an accepted request
    always_ff @(posedge clk_wfi or negedge rstn_sync) begin
        if (!rstn_sync) begin
            imem_en_o     <= 1'b0;
            imem_addr_o   <= rv_core_pkg::RESET_PC;
            fetch_valid_o <= 1'b0;
        end else begin
            imem_en_o     <= 1'b1;
            fetch_valid_o <= accept;
            if (accept) begin
                imem_addr_o <= imem_addr_o + rv_core_pkg::PC_STEP;
            end
        end
    end

    // PC of the word returned next cycle
    always_ff @(posedge clk_wfi) begin
        if (accept) begin
            fetch_pc_o <= imem_addr_o;
        end
    end

endmodule

`default_nettype wire

//--- rv_regfile.sv
`default_nettype none

module rv_regfile (
    input  logic                           clk_wfi,
    input  logic                           rstn_sync,
    input  logic                           wr_i,
    input  logic [rv_core_pkg::REG_AW-1:0] wr_addr_i,
    input  logic [rv_core_pkg::XLEN-1:0]   wr_data_i,
    input  logic [rv_core_pkg::REG_AW-1:0] rs1_addr_i,
    input  logic [rv_core_pkg::REG_AW-1:0] rs2_addr_i,
    output logic [rv_core_pkg::XLEN-1:0]   rs1_data_o,
    output logic [rv_core_pkg::XLEN-1:0]   rs2_data_o
);

    logic [rv_core_pkg::XLEN-1:0] regs [1:31];

    // x0 reads zero, a same-cycle write passes straight through
    function automatic logic [rv_core_pkg::XLEN-1:0] read_port(
        input logic [rv_core_pkg::REG_AW-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end
        if (wr_i && (wr_addr_i == addr)) begin
            return wr_data_i;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk_wfi or negedge rstn_sync) begin
        if (!rstn_sync) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

endmodule

`default_nettype wire

//--- rv_decode.sv
`default_nettype none

module rv_decode (
    input  logic                             clk_wfi,
    input  logic                             rstn_sync,
    input  logic                             fetch_valid_i,
    input  logic [rv_core_pkg::PC_W-1:0]     fetch_pc_i,
    input  logic [rv_isa_pkg::INST_W-1:0]    inst_i,
    input  logic                             wb_rd_wr_i,
    input  logic [rv_core_pkg::REG_AW-1:0]   wb_rd_addr_i,
    input  logic [rv_core_pkg::XLEN-1:0]     wb_rd_data_i,
    output logic                             ex_valid_o,
    output logic [rv_core_pkg::PC_W-1:0]     ex_pc_o,
    output rv_core_pkg::alu_op_e             ex_alu_op_o,
    output logic [rv_core_pkg::REG_AW-1:0]   ex_rs1_addr_o,
    output logic [rv_core_pkg::REG_AW-1:0]   ex_rs2_addr_o,
    output logic [rv_core_pkg::XLEN-1:0]     ex_rs1_data_o,
    output logic [rv_core_pkg::XLEN-1:0]     ex_rs2_data_o,
    output logic [rv_core_pkg::XLEN-1:0]     ex_imm_o,
    output logic                             ex_use_imm_o,
    output logic                             ex_rd_wr_o,
    output logic [rv_core_pkg::REG_AW-1:0]   ex_rd_addr_o,
    output logic                             ex_illegal_o
);

    logic [rv_isa_pkg::OPCODE_W-1:0] opcode;
    logic [2:0]                      funct3;
    logic [6:0]                      funct7;
    logic [rv_core_pkg::REG_AW-1:0]  rd_addr;
    logic [rv_core_pkg::REG_AW-1:0]  rs1_addr;
    logic [rv_core_pkg::REG_AW-1:0]  rs2_addr;
    logic [rv_core_pkg::XLEN-1:0]    rs1_data;
    logic [rv_core_pkg::XLEN-1:0]    rs2_data;
    logic [rv_core_pkg::XLEN-1:0]    imm_i;
    logic [rv_core_pkg::XLEN-1:0]    imm_u;
    logic [rv_core_pkg::XLEN-1:0]    imm;
    logic                            alt;
    logic                            f7_zero;
    rv_core_pkg::alu_op_e            base_op;
    rv_core_pkg::alu_op_e            alu_op;
    logic                            use_imm;
    logic                            illegal;

    assign opcode   = inst_i[rv_isa_pkg::OPCODE_W-1:0];
    assign rd_addr  = inst_i[rv_isa_pkg::RD_LSB +: rv_core_pkg::REG_AW];
    assign funct3   = inst_i[rv_isa_pkg::FUNCT3_LSB +: 3];
    assign rs1_addr = inst_i[rv_isa_pkg::RS1_LSB +: rv_core_pkg::REG_AW];
    assign rs2_addr = inst_i[rv_isa_pkg::RS2_LSB +: rv_core_pkg::REG_AW];
    assign funct7   = inst_i[rv_isa_pkg::FUNCT7_LSB +: 7];

    assign imm_i   = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u   = {inst_i[31:12], 12'b0};
    assign alt     = (funct7 == rv_isa_pkg::FUNCT7_ALT);
    assign f7_zero = (funct7 == 7'b0);

    rv_regfile rv_regfile_inst (
        .clk_wfi    ( clk_wfi      ),
        .rstn_sync  ( rstn_sync    ),
        .wr_i       ( wb_rd_wr_i   ),
        .wr_addr_i  ( wb_rd_addr_i ),
        .wr_data_i  ( wb_rd_data_i ),
        .rs1_addr_i ( rs1_addr     ),
        .rs2_addr_i ( rs2_addr     ),
        .rs1_data_o ( rs1_data     ),
        .rs2_data_o ( rs2_data     )
    );

    // Shared by both the immediate and the register group
    always_comb begin
        case (funct3)
            rv_isa_pkg::F3_ADD:  base_op = rv_core_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:  base_op = rv_core_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:  base_op = rv_core_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU: base_op = rv_core_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:  base_op = rv_core_pkg::ALU_XOR;
            rv_isa_pkg::F3_SR:   base_op = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:   base_op = rv_core_pkg::ALU_OR;
            default:             base_op = rv_core_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        alu_op  = base_op;
        use_imm = 1'b1;
        imm     = imm_i;
        illegal = 1'b0;
        case (opcode)
            rv_isa_pkg::OP_IMM: begin
                // funct7 only matters for shifts
                if (funct3 == rv_isa_pkg::F3_SLL) begin
                    illegal = !f7_zero;
                end else if (funct3 == rv_isa_pkg::F3_SR) begin
                    illegal = !f7_zero && !alt;
                end
            end
            rv_isa_pkg::OP: begin
                use_imm = 1'b0;
                if (alt && (funct3 == rv_isa_pkg::F3_ADD)) begin
                    alu_op = rv_core_pkg::ALU_SUB;
                end
                illegal = !f7_zero && !(alt && ((funct3 == rv_isa_pkg::F3_ADD) ||
                                                (funct3 == rv_isa_pkg::F3_SR)));
            end
            rv_isa_pkg::LUI: begin
                alu_op = rv_core_pkg::ALU_PASS_B;
                imm    = imm_u;
            end
            default: illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk_wfi or negedge rstn_sync) begin
        if (!rstn_sync) begin
            ex_valid_o   <= 1'b0;
            ex_rd_wr_o   <= 1'b0;
            ex_illegal_o <= 1'b0;
        end else begin
            ex_valid_o   <= fetch_valid_i;
            ex_rd_wr_o   <= fetch_valid_i && !illegal && (rd_addr != '0);
            ex_illegal_o <= fetch_valid_i && illegal;
        end
    end

    always_ff @(posedge clk_wfi) begin
        ex_pc_o       <= fetch_pc_i;
        ex_alu_op_o   <= alu_op;
        ex_rs1_addr_o <= rs1_addr;
        ex_rs2_addr_o <= rs2_addr;
        ex_rs1_data_o <= rs1_data;
        ex_rs2_data_o <= rs2_data;
        ex_imm_o      <= imm;
        ex_use_imm_o  <= use_imm;
        ex_rd_addr_o  <= rd_addr;
    end

endmodule

`default_nettype wire

//--- rv_execute.sv
`default_nettype none

module rv_execute (
    input  rv_core_pkg::alu_op_e             ex_alu_op_i,
    input  logic [rv_core_pkg::REG_AW-1:0]   ex_rs1_addr_i,
    input  logic [rv_core_pkg::REG_AW-1:0]   ex_rs2_addr_i,
    input  logic [rv_core_pkg::XLEN-1:0]     ex_rs1_data_i,
    input  logic [rv_core_pkg::XLEN-1:0]     ex_rs2_data_i,
    input  logic [rv_core_pkg::XLEN-1:0]     ex_imm_i,
    input  logic                             ex_use_imm_i,
    input  logic                             wb_rd_wr_i,
    input  logic [rv_core_pkg::REG_AW-1:0]   wb_rd_addr_i,
    input  logic [rv_core_pkg::XLEN-1:0]     wb_rd_data_i,
    output logic [rv_core_pkg::XLEN-1:0]     ex_result_o
);

    logic [rv_core_pkg::XLEN-1:0] rs1_fwd;
    logic [rv_core_pkg::XLEN-1:0] rs2_fwd;
    logic [rv_core_pkg::XLEN-1:0] op_a;
    logic [rv_core_pkg::XLEN-1:0] op_b;
    logic [4:0]                   shamt;
    logic                         lt_signed;
    logic                         lt_unsigned;

    // wb_rd_wr_i is never set for x0
    assign rs1_fwd = (wb_rd_wr_i && (wb_rd_addr_i == ex_rs1_addr_i)) ? wb_rd_data_i
                                                                      : ex_rs1_data_i;
    assign rs2_fwd = (wb_rd_wr_i && (wb_rd_addr_i == ex_rs2_addr_i)) ? wb_rd_data_i
                                                                      : ex_rs2_data_i;

    assign op_a  = rs1_fwd;
    assign op_b  = ex_use_imm_i ? ex_imm_i : rs2_fwd;
    assign shamt = op_b[4:0];

    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        case (ex_alu_op_i)
            rv_core_pkg::ALU_ADD:  ex_result_o = op_a + op_b;
            rv_core_pkg::ALU_SUB:  ex_result_o = op_a - op_b;
            rv_core_pkg::ALU_SLL:  ex_result_o = op_a << shamt;
            rv_core_pkg::ALU_SLT:  ex_result_o = {{(rv_core_pkg::XLEN-1){1'b0}}, lt_signed};
            rv_core_pkg::ALU_SLTU: ex_result_o = {{(rv_core_pkg::XLEN-1){1'b0}}, lt_unsigned};
            rv_core_pkg::ALU_XOR:  ex_result_o = op_a ^ op_b;
            rv_core_pkg::ALU_SRL:  ex_result_o = op_a >> shamt;
            rv_core_pkg::ALU_SRA:  ex_result_o = $unsigned($signed(op_a) >>> shamt);
            rv_core_pkg::ALU_OR:   ex_result_o = op_a | op_b;
            rv_core_pkg::ALU_AND:  ex_result_o = op_a & op_b;
            default:               ex_result_o = op_b;
        endcase
    end

endmodule

`default_nettype wire

//--- rv_retire.sv
`default_nettype none

module rv_retire (
    input  logic                             clk_wfi,
    input  logic                             rstn_sync,
    input  logic                             ex_valid_i,
    input  logic [rv_core_pkg::PC_W-1:0]     ex_pc_i,
    input  logic                             ex_illegal_i,
    input  logic                             ex_rd_wr_i,
    input  logic [rv_core_pkg::REG_AW-1:0]   ex_rd_addr_i,
    input  logic [rv_core_pkg::XLEN-1:0]     ex_result_i,
    output logic                             wb_rd_wr_o,
    output logic [rv_core_pkg::REG_AW-1:0]   wb_rd_addr_o,
    output logic [rv_core_pkg::XLEN-1:0]     wb_rd_data_o,
    output logic                             retire_valid_o,
    output logic [rv_core_pkg::PC_W-1:0]     retire_pc_o,
    output logic                             retire_illegal_o
);

    always_ff @(posedge clk_wfi or negedge rstn_sync) begin
        if (!rstn_sync) begin
            wb_rd_wr_o       <= 1'b0;
            retire_valid_o   <= 1'b0;
            retire_illegal_o <= 1'b0;
        end else begin
            wb_rd_wr_o       <= ex_rd_wr_i;
            retire_valid_o   <= ex_valid_i;
            retire_illegal_o <= ex_illegal_i;
        end
    end

    // Also the forwarding source for execute
    always_ff @(posedge clk_wfi) begin
        wb_rd_addr_o <= ex_rd_addr_i;
        wb_rd_data_o <= ex_result_i;
        retire_pc_o  <= ex_pc_i;
    end

endmodule

`default_nettype wire

//--- rv_core.sv
`default_nettype none

module rv_core (
    input  logic                             clk_wfi,
    input  logic                             rstn_sync,
    output logic                             imem_en_o,
    output logic [rv_core_pkg::PC_W-1:0]     imem_addr_o,
    input  logic [rv_core_pkg::XLEN-1:0]     imem_rdata_i,
    input  logic                             imem_busy_i,
    output logic                             retire_valid_o,
    output logic [rv_core_pkg::PC_W-1:0]     retire_pc_o,
    output logic                             retire_illegal_o,
    output logic                             retire_rd_wr_o,
    output logic [rv_core_pkg::REG_AW-1:0]   retire_rd_addr_o,
    output logic [rv_core_pkg::XLEN-1:0]     retire_rd_data_o
);

    logic                           fetch_valid;
    logic [rv_core_pkg::PC_W-1:0]   fetch_pc;
    logic                           ex_valid;
    logic [rv_core_pkg::PC_W-1:0]   ex_pc;
    rv_core_pkg::alu_op_e           ex_alu_op;
    logic [rv_core_pkg::REG_AW-1:0] ex_rs1_addr;
    logic [rv_core_pkg::REG_AW-1:0] ex_rs2_addr;
    logic [rv_core_pkg::XLEN-1:0]   ex_rs1_data;
    logic [rv_core_pkg::XLEN-1:0]   ex_rs2_data;
    logic [rv_core_pkg::XLEN-1:0]   ex_imm;
    logic                           ex_use_imm;
    logic                           ex_rd_wr;
    logic [rv_core_pkg::REG_AW-1:0] ex_rd_addr;
    logic                           ex_illegal;
    logic [rv_core_pkg::XLEN-1:0]   ex_result;

    rv_fetch rv_fetch_inst (
        .clk_wfi       ( clk_wfi     ),
        .rstn_sync     ( rstn_sync   ),
        .imem_busy_i   ( imem_busy_i ),
        .imem_en_o     ( imem_en_o   ),
        .imem_addr_o   ( imem_addr_o ),
        .fetch_valid_o ( fetch_valid ),
        .fetch_pc_o    ( fetch_pc    )
    );

    // Writeback port doubles as the retire record
    rv_decode rv_decode_inst (
        .clk_wfi       ( clk_wfi          ),
        .rstn_sync     ( rstn_sync        ),
        .fetch_valid_i ( fetch_valid      ),
        .fetch_pc_i    ( fetch_pc         ),
        .inst_i        ( imem_rdata_i     ),
        .wb_rd_wr_i    ( retire_rd_wr_o   ),
        .wb_rd_addr_i  ( retire_rd_addr_o ),
        .wb_rd_data_i  ( retire_rd_data_o ),
        .ex_valid_o    ( ex_valid         ),
        .ex_pc_o       ( ex_pc            ),
        .ex_alu_op_o   ( ex_alu_op        ),
        .ex_rs1_addr_o ( ex_rs1_addr      ),
        .ex_rs2_addr_o ( ex_rs2_addr      ),
        .ex_rs1_data_o ( ex_rs1_data      ),
        .ex_rs2_data_o ( ex_rs2_data      ),
        .ex_imm_o      ( ex_imm           ),
        .ex_use_imm_o  ( ex_use_imm       ),
        .ex_rd_wr_o    ( ex_rd_wr         ),
        .ex_rd_addr_o  ( ex_rd_addr       ),
        .ex_illegal_o  ( ex_illegal       )
    );

    rv_execute rv_execute_inst (
        .ex_alu_op_i   ( ex_alu_op        ),
        .ex_rs1_addr_i ( ex_rs1_addr      ),
        .ex_rs2_addr_i ( ex_rs2_addr      ),
        .ex_rs1_data_i ( ex_rs1_data      ),
        .ex_rs2_data_i ( ex_rs2_data      ),
        .ex_imm_i      ( ex_imm           ),
        .ex_use_imm_i  ( ex_use_imm       ),
        .wb_rd_wr_i    ( retire_rd_wr_o   ),
        .wb_rd_addr_i  ( retire_rd_addr_o ),
        .wb_rd_data_i  ( retire_rd_data_o ),
        .ex_result_o   ( ex_result        )
    );

    rv_retire rv_retire_inst (
        .clk_wfi          ( clk_wfi          ),
        .rstn_sync        ( rstn_sync        ),
        .ex_valid_i       ( ex_valid         ),
        .ex_pc_i          ( ex_pc            ),
        .ex_illegal_i     ( ex_illegal       ),
        .ex_rd_wr_i       ( ex_rd_wr         ),
        .ex_rd_addr_i     ( ex_rd_addr       ),
        .ex_result_i      ( ex_result        ),
        .wb_rd_wr_o       ( retire_rd_wr_o   ),
        .wb_rd_addr_o     ( retire_rd_addr_o ),
        .wb_rd_data_o     ( retire_rd_data_o ),
        .retire_valid_o   ( retire_valid_o   ),
        .retire_pc_o      ( retire_pc_o      ),
        .retire_illegal_o ( retire_illegal_o )
    );

endmodule

`default_nettype wire

//--- rv_core_chk.sv
`default_nettype none

module rv_core_chk (
    input logic                             clk_wfi,
    input logic                             rstn_sync,
    input logic                             imem_en_i,
    input logic [rv_core_pkg::PC_W-1:0]     imem_addr_i,
    input logic                             imem_busy_i,
    input logic                             retire_valid_i,
    input logic [rv_core_pkg::PC_W-1:0]     retire_pc_i,
    input logic                             retire_illegal_i,
    input logic                             retire_rd_wr_i,
    input logic [rv_core_pkg::REG_AW-1:0]   retire_rd_addr_i
);

    // A stalled request keeps its address
    a_addr_hold: assert property (@(posedge clk_wfi) disable iff (!rstn_sync)
        $past(imem_en_i && imem_busy_i) |-> (imem_addr_i == $past(imem_addr_i)))
        else $error("imem_addr_o moved while the request was stalled");

    a_pc_aligned: assert property (@(posedge clk_wfi) disable iff (!rstn_sync)
        retire_valid_i |-> (retire_pc_i[1:0] == 2'b00))
        else $error("retire_pc_o is not word aligned");

    a_wr_legal: assert property (@(posedge clk_wfi) disable iff (!rstn_sync)
        retire_rd_wr_i |-> (retire_valid_i && (retire_rd_addr_i != '0) && !retire_illegal_i))
        else $error("register write on an invalid, x0 or illegal retirement");

    // Shortest path from release to retire is longer than three cycles
    a_no_early_retire: assert property (@(posedge clk_wfi)
        retire_valid_i |-> ($past(rstn_sync, 1) && $past(rstn_sync, 2) && $past(rstn_sync, 3)))
        else $error("retirement within three cycles of reset release");

endmodule

bind rv_core rv_core_chk rv_core_chk_inst (
    .clk_wfi          ( clk_wfi          ),
    .rstn_sync        ( rstn_sync        ),
    .imem_en_i        ( imem_en_o        ),
    .imem_addr_i      ( imem_addr_o      ),
    .imem_busy_i      ( imem_busy_i      ),
    .retire_valid_i   ( retire_valid_o   ),
    .retire_pc_i      ( retire_pc_o      ),
    .retire_illegal_i ( retire_illegal_o ),
    .retire_rd_wr_i   ( retire_rd_wr_o   ),
    .retire_rd_addr_i ( retire_rd_addr_o )
);

`default_nettype wire

//--- rv_core_tb.sv
`default_nettype none

module rv_core_tb;

    logic                             clk_wfi;
    logic                             rstn_sync;
    logic                             imem_en;
    logic [rv_core_pkg::PC_W-1:0]     imem_addr;
    logic [rv_core_pkg::XLEN-1:0]     imem_rdata;
    logic                             imem_busy;
    logic                             retire_valid;
    logic [rv_core_pkg::PC_W-1:0]     retire_pc;
    logic                             retire_illegal;
    logic                             retire_rd_wr;
    logic [rv_core_pkg::REG_AW-1:0]   retire_rd_addr;
    logic [rv_core_pkg::XLEN-1:0]     retire_rd_data;

    logic [31:0] mem [0:1023];
    logic [31:0] ref_regs [0:31];
    // {illegal, rd_wr, rd_addr, pc, data}
    logic [70:0] exp_q [$];
    logic [9:0]  load_ptr;
    int          fetch_budget;
    logic        busy_random;
    logic [15:0] lfsr_state;
    logic        run_ended;

    rv_core rv_core_inst (
        .clk_wfi          ( clk_wfi        ),
        .rstn_sync        ( rstn_sync      ),
        .imem_en_o        ( imem_en        ),
        .imem_addr_o      ( imem_addr      ),
        .imem_rdata_i     ( imem_rdata     ),
        .imem_busy_i      ( imem_busy      ),
        .retire_valid_o   ( retire_valid   ),
        .retire_pc_o      ( retire_pc      ),
        .retire_illegal_o ( retire_illegal ),
        .retire_rd_wr_o   ( retire_rd_wr   ),
        .retire_rd_addr_o ( retire_rd_addr ),
        .retire_rd_data_o ( retire_rd_data )
    );

    initial begin
        clk_wfi = 1'b0;
        forever #2 clk_wfi = ~clk_wfi;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic [31:0] encode_itype(input logic [2:0] f3, input logic [4:0] rd,
                                                 input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, rv_isa_pkg::OP_IMM};
    endfunction

    function automatic logic [31:0] encode_rtype(input logic [6:0] f7, input logic [2:0] f3,
                                                 input logic [4:0] rd, input logic [4:0] rs1,
                                                 input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP};
    endfunction

    function automatic logic [31:0] encode_lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, rv_isa_pkg::LUI};
    endfunction

    function automatic logic [31:0] random_alu_inst(input logic [4:0] rd, input logic [4:0] rs1,
                                                    input logic [4:0] rs2);
        logic [2:0] f3;
        logic [6:0] f7;
        logic       use_imm;
        f3 = 3'(rand_bits(3));
        use_imm = lfsr_bit();
        f7 = 7'd0;
        if (((f3 == 3'd5) || ((f3 == 3'd0) && !use_imm)) && lfsr_bit()) begin
            f7 = rv_isa_pkg::FUNCT7_ALT;
        end
        if (!use_imm) begin
            return encode_rtype(f7, f3, rd, rs1, rs2);
        end
        if ((f3 == 3'd1) || (f3 == 3'd5)) begin
            return encode_itype(f3, rd, rs1, {f7, 5'(rand_bits(5))});
        end
        return encode_itype(f3, rd, rs1, 12'(rand_bits(12)));
    endfunction

    // ISA semantics on the model's own registers
    function automatic logic [70:0] ref_step(input logic [31:0] inst, input logic [31:0] pc);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        legal;
        logic        alt;
        f3 = inst[14:12];
        f7 = inst[31:25];
        rd = inst[11:7];
        a = ref_regs[inst[19:15]];
        b = ref_regs[inst[24:20]];
        alt = (f7 == rv_isa_pkg::FUNCT7_ALT);
        legal = 1'b1;
        if (inst[6:0] == rv_isa_pkg::OP_IMM) begin
            b = {{20{inst[31]}}, inst[31:20]};
            if (f3 == 3'd1) begin
                legal = (f7 == 7'd0);
            end else if (f3 == 3'd5) begin
                legal = (f7 == 7'd0) || alt;
            end
            alt = alt && (f3 == 3'd5);
        end else if (inst[6:0] == rv_isa_pkg::OP) begin
            legal = (f7 == 7'd0) || (alt && ((f3 == 3'd0) || (f3 == 3'd5)));
        end else if (inst[6:0] != rv_isa_pkg::LUI) begin
            legal = 1'b0;
        end
        case (f3)
            3'd0: res = alt ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = {31'd0, $signed(a) < $signed(b)};
            3'd3: res = {31'd0, a < b};
            3'd4: res = a ^ b;
            3'd5: res = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        if (inst[6:0] == rv_isa_pkg::LUI) begin
            res = {inst[31:12], 12'd0};
        end
        if (legal && (rd != 5'd0)) begin
            ref_regs[rd] = res;
        end
        return {!legal, legal && (rd != 5'd0), rd, pc, res};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        run_ended = 1'b1;
        $display("[ERROR] %s = 0x%h, expected 0x%h", name, got, want);
        $display("Testbench failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_failure(input string what);
        run_ended = 1'b1;
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "check failed");
    endtask

    task automatic add_inst(input logic [31:0] inst);
        mem[load_ptr] = inst;
        exp_q.push_back(ref_step(inst, {20'd0, load_ptr, 2'b00}));
        load_ptr++;
    endtask

    task automatic check_retire();
        logic [70:0] e;
        e = exp_q.pop_front();
        assert (retire_pc == e[63:32]) else report_mismatch("retire_pc_o", retire_pc, e[63:32]);
        assert (retire_illegal == e[70])
            else report_mismatch("retire_illegal_o", 32'(retire_illegal), 32'(e[70]));
        assert (retire_rd_wr == e[69])
            else report_mismatch("retire_rd_wr_o", 32'(retire_rd_wr), 32'(e[69]));
        if (e[69]) begin
            assert (retire_rd_addr == e[68:64])
                else report_mismatch("retire_rd_addr_o", 32'(retire_rd_addr), 32'(e[68:64]));
            assert (retire_rd_data == e[31:0])
                else report_mismatch("retire_rd_data_o", retire_rd_data, e[31:0]);
        end
    endtask

    // Release fetch for the loaded program and check every retirement in order
    task automatic run_program(input int unsigned limit);
        int unsigned cycles;
        fetch_budget = exp_q.size();
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk_wfi);
            if (retire_valid) begin
                check_retire();
            end
            cycles++;
            assert (cycles < limit) else report_failure("Timeout waiting for retirements");
        end
        repeat (4) begin
            @(negedge clk_wfi);
            assert (!retire_valid) else report_failure("Extra retirement after the program");
        end
    endtask

    task automatic test_reset_fetch();
        int unsigned cycles;
        cycles = 0;
        while (!imem_en) begin
            @(negedge clk_wfi);
            assert (!retire_valid) else report_failure("Retirement before the first fetch");
            cycles++;
            assert (cycles < 10) else report_failure("Timeout waiting for imem_en_o after reset");
        end
        assert (imem_addr == rv_core_pkg::RESET_PC)
            else report_mismatch("imem_addr_o", imem_addr, rv_core_pkg::RESET_PC);
        repeat (6) begin
            @(negedge clk_wfi);
            assert (!retire_valid) else report_failure("Retirement while fetch is held off");
        end
        for (int i = 0; i < 4; i++) begin
            add_inst(encode_itype(rv_isa_pkg::F3_ADD, 5'(i + 1), 5'd0, 12'(i)));
        end
        run_program(40);
    endtask

    task automatic test_imm_ops();
        logic [4:0] rd;
        logic [4:0] rs1;
        for (int r = 1; r < 32; r++) begin
            add_inst(encode_lui(5'(r), 20'(rand_bits(20))));
            add_inst(encode_itype(rv_isa_pkg::F3_OR, 5'(r), 5'(r), 12'(rand_bits(12))));
        end
        for (int n = 0; n < 3; n++) begin
            for (int f = 0; f < 8; f++) begin
                rd = 5'(rand_bits(5));
                rs1 = 5'(rand_bits(5));
                if ((f == 1) || (f == 5)) begin
                    add_inst(encode_itype(3'(f), rd, rs1, {7'd0, 5'(rand_bits(5))}));
                end else begin
                    add_inst(encode_itype(3'(f), rd, rs1, 12'(rand_bits(12))));
                end
            end
            add_inst(encode_itype(rv_isa_pkg::F3_SR, 5'(rand_bits(5)), 5'(rand_bits(5)),
                                  {rv_isa_pkg::FUNCT7_ALT, 5'(rand_bits(5))}));
            add_inst(encode_lui(5'(rand_bits(5)), 20'(rand_bits(20))));
        end
        run_program(300);
    endtask

    task automatic test_reg_ops();
        for (int n = 0; n < 3; n++) begin
            for (int f = 0; f < 10; f++) begin
                add_inst(encode_rtype((f > 7) ? rv_isa_pkg::FUNCT7_ALT : 7'd0,
                                      (f == 9) ? 3'd5 : 3'(f), 5'(rand_bits(5)),
                                      5'(rand_bits(5)), 5'(rand_bits(5))));
            end
        end
        run_program(150);
    endtask

    // Each result feeds the next two instructions
    task automatic test_dependent_chains();
        logic [4:0] prev1;
        logic [4:0] prev2;
        logic [4:0] rd;
        prev1 = 5'd1;
        prev2 = 5'd2;
        for (int n = 0; n < 24; n++) begin
            rd = 5'((n % 28) + 3);
            // Odd steps swap the sources so each port sees both paths
            if ((n % 2) == 1) begin
                add_inst(random_alu_inst(rd, prev2, prev1));
            end else begin
                add_inst(random_alu_inst(rd, prev1, prev2));
            end
            prev2 = prev1;
            prev1 = rd;
        end
        run_program(150);
    endtask

    task automatic test_busy_bubbles();
        logic [4:0] prev;
        logic [4:0] rd;
        prev = 5'd4;
        busy_random = 1'b1;
        for (int n = 0; n < 40; n++) begin
            rd = 5'(rand_bits(5));
            add_inst(random_alu_inst(rd, prev, 5'(rand_bits(5))));
            prev = rd;
        end
        run_program(600);
        busy_random = 1'b0;
    endtask

    task automatic test_x0_and_illegal();
        add_inst(encode_itype(rv_isa_pkg::F3_ADD, 5'd0, 5'd1, 12'h123));
        add_inst(encode_rtype(7'd0, rv_isa_pkg::F3_ADD, 5'd5, 5'd0, 5'd0));
        // LW is outside the supported set
        add_inst(32'h0000_2003);
        add_inst(encode_rtype(7'h01, rv_isa_pkg::F3_ADD, 5'd6, 5'd1, 5'd2));
        add_inst(encode_itype(rv_isa_pkg::F3_SLL, 5'd7, 5'd1, {rv_isa_pkg::FUNCT7_ALT, 5'd3}));
        add_inst(encode_rtype(rv_isa_pkg::FUNCT7_ALT, rv_isa_pkg::F3_XOR, 5'd8, 5'd1, 5'd2));
        add_inst(32'hFFFF_FFFF);
        add_inst(encode_itype(rv_isa_pkg::F3_OR, 5'd9, 5'd0, 12'h000));
        run_program(60);
    endtask

    // Answers each accepted address in the next cycle
    initial begin : imem_model
        logic        accept;
        logic [31:0] addr;
        forever begin
            @(negedge clk_wfi);
            accept = imem_en && !imem_busy;
            addr = imem_addr;
            @(posedge clk_wfi);
            #1;
            if (accept) begin
                imem_rdata = mem[addr[11:2]];
                fetch_budget--;
            end else begin
                imem_rdata = rv_isa_pkg::INST_NOP;
            end
            imem_busy = (fetch_budget == 0) || (busy_random && lfsr_bit());
        end
    end

    initial begin
        rstn_sync = 1'b0;
        imem_busy = 1'b1;
        imem_rdata = rv_isa_pkg::INST_NOP;
        fetch_budget = 0;
        busy_random = 1'b0;
        lfsr_state = 16'd54;
        run_ended = 1'b0;
        load_ptr = rv_core_pkg::RESET_PC[11:2];
        ref_regs = '{default: '0};
        repeat (8) @(posedge clk_wfi);
        #1;
        rstn_sync = 1'b1;
        test_reset_fetch();
        test_imm_ops();
        test_reg_ops();
        test_dependent_chains();
        test_busy_bubbles();
        test_x0_and_illegal();
        run_ended = 1'b1;
        $display("Testbench passed");
        $finish;
    end

    // Reached only when a bound assertion stopped the run
    final begin
        if (!run_ended) begin
            $display("Testbench failed");
        end
    end

endmodule

`default_nettype wire

//--- rv_core.f
rv_isa_pkg.sv
rv_core_pkg.sv
rv_fetch.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_retire.sv
rv_core.sv
rv_core_chk.sv
rv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := rv_core_tb
FILELIST  := rv_core.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
